//--- source/loader_pkg.sv
// Host loader shared widths, constants and packed bus types
package loader_pkg;

	// ==============================
	// Widths
	// ==============================
	localparam int rom_addr_w    = 24;
	localparam int word_w        = 16;
	localparam int cheat_w       = 128;
	localparam int bram_addr_w   = 11; // 2 KB of core byte address
	localparam int sector_count  = 16;
	localparam int sector_word_w = 8;  // 256 words per 512-byte sector
	localparam int sector_sel_w  = $clog2(sector_count);
	localparam int bram_word_aw  = sector_sel_w + sector_word_w; // Host word port reach

	// Download index decoding
	localparam logic [4:0] cart_index_sgx = 5'd2;
	localparam logic [7:0] code_index     = 8'hFF;

	// Populous signature checked in two 16-byte pages (address bits 23..4)
	localparam logic [rom_addr_w-5:0] pop_page_a = 20'h1F2;
	localparam logic [rom_addr_w-5:0] pop_page_b = 20'h212;
	localparam logic [3:0][word_w-1:0] pop_sig = {16'h5355, 16'h4F4C, 16'h5550, 16'h4F50};

	// Backup RAM header written by a format ("HUBM" plus sizes)
	localparam logic [3:0][word_w-1:0] bram_default = {16'h8010, 16'h8800, 16'h4D42, 16'h5548};

	// ==============================
	// Bus types
	// ==============================
	typedef struct packed {
		logic                wr;
		logic [rom_addr_w:0] addr; // 25-bit host byte address
		logic [word_w-1:0]   data;
	} host_wr_t;

	typedef struct packed {
		logic                  req; // Toggles once per word
		logic [rom_addr_w-1:0] addr;
		logic [word_w-1:0]     data;
	} rom_wr_t;

	typedef struct packed {
		logic [7:0] size;
		logic       header;
		logic       populous;
		logic       sgx;
	} rom_info_t;

	typedef struct packed {
		logic [cheat_w/4-1:0] flags;
		logic [cheat_w/4-1:0] addr;
		logic [cheat_w/4-1:0] compare;
		logic [cheat_w/4-1:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sector_req_t;

	typedef struct packed {
		logic [sector_word_w-1:0] addr;
		logic [word_w-1:0]        data;
		logic                     wr;
	} sector_buf_t;

	typedef struct packed {
		logic rom_swap;
		logic autosave;
		logic bk_load;
		logic bk_save;
		logic format;
	} loader_opts_t;

endpackage

//--- source/rom_loader.sv
// ROM loader that writes host words to memory by toggle handshake and tracks image flags
module rom_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_download,
	input  logic [7:0]            download_index,
	input  loader_pkg::host_wr_t  host_wr,
	input  logic                  rom_swap,
	input  logic                  rom_ack,
	output logic                  ioctl_wait,
	output loader_pkg::rom_wr_t   rom_wr,
	output loader_pkg::rom_info_t rom_info
);

	logic                              old_download;
	logic                              req;
	logic [loader_pkg::rom_addr_w-1:0] addr;
	logic [loader_pkg::word_w-1:0]     rev_data;
	logic [loader_pkg::word_w-1:0]     wr_word;
	logic [loader_pkg::word_w-1:0]     wr_data;
	logic [1:0]                        populous; // One flag per signature page
	logic                              sgx;
	logic                              accept;
	logic                              in_page;
	logic                              sig_slot;
	logic [3:0]                        sig_off;

	// ==============================
	// Write data path
	// ==============================
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			rev_data[i]     = host_wr.data[7 - i];
			rev_data[8 + i] = host_wr.data[15 - i];
		end
	end

	assign wr_word = rom_swap ? rev_data : host_wr.data;
	assign accept  = host_wr.wr & cart_download;

	// Signature words sit at offsets 6..12 of either page
	assign in_page  = (addr[23:4] == loader_pkg::pop_page_a) ||
			(addr[23:4] == loader_pkg::pop_page_b);
	assign sig_off  = addr[3:0] - 4'd6;
	assign sig_slot = in_page && (addr[3:0] inside {[4'd6:4'd12]});

	// ==============================
	// Handshake and flags
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			ioctl_wait   <= 1'b0;
			req          <= 1'b0;
			addr         <= '0;
			populous     <= 2'b11;
			sgx          <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download) begin
				addr     <= '0;
				populous <= 2'b11;
				sgx      <= (download_index[4:0] == loader_pkg::cart_index_sgx);
			end else if (accept) begin
				ioctl_wait <= 1'b1; // Hold the host until the memory answers
				req        <= ~req;
				if (sig_slot && (wr_word != loader_pkg::pop_sig[sig_off[2:1]]))
					populous[addr[13]] <= 1'b0;
			end else if (ioctl_wait && (req == rom_ack)) begin
				ioctl_wait <= 1'b0;
				addr       <= addr + (loader_pkg::rom_addr_w)'(2);
			end
		end
	end

	// Word latched with the request
	always_ff @(posedge clk_sys) begin
		if (accept)
			wr_data <= wr_word;
	end

	assign rom_wr = '{
		req:  req,
		addr: addr,
		data: wr_data
	};

	// Header bit shifts the image by 512 bytes and picks the matching page
	assign rom_info = '{
		size:     addr[23:16],
		header:   addr[9],
		populous: populous[addr[9]],
		sgx:      sgx
	};

endmodule

//--- source/cheat_assembler.sv
// Cheat code assembler that gathers eight host words into one 128-bit code
module cheat_assembler (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    code_download,
	input  logic                    download,
	input  loader_pkg::host_wr_t    host_wr,
	output loader_pkg::cheat_code_t cheat_code,
	output logic                    code_valid,
	output logic                    cheat_clear
);

	logic code_wr;

	assign code_wr = code_download & host_wr.wr;

	// Low word first for every field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (host_wr.addr[3:0])
				4'd0:    cheat_code.flags[15:0]    <= host_wr.data;
				4'd2:    cheat_code.flags[31:16]   <= host_wr.data;
				4'd4:    cheat_code.addr[15:0]     <= host_wr.data;
				4'd6:    cheat_code.addr[31:16]    <= host_wr.data;
				4'd8:    cheat_code.compare[15:0]  <= host_wr.data;
				4'd10:   cheat_code.compare[31:16] <= host_wr.data;
				4'd12:   cheat_code.replace[15:0]  <= host_wr.data;
				4'd14:   cheat_code.replace[31:16] <= host_wr.data;
				default: ;
			endcase
		end
	end

	// ==============================
	// Strobes to the core
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid  <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			code_valid  <= code_wr && (host_wr.addr[3:0] == 4'd14); // Last word completes it
			cheat_clear <= download && host_wr.wr && (host_wr.addr == '0);
		end
	end

endmodule

//--- source/backup_ram.sv
// Backup RAM holding battery saves behind a core byte port and a host word port
module backup_ram (
	input  logic                                clk_sys,
	input  logic [loader_pkg::bram_addr_w-1:0]  bram_addr,
	input  logic [7:0]                          bram_wdata,
	input  logic                                bram_we,
	output logic [7:0]                          bram_rdata,
	input  logic [loader_pkg::bram_word_aw-1:0] word_addr,
	input  logic [loader_pkg::word_w-1:0]       word_wdata,
	input  logic                                word_we,
	output logic [loader_pkg::word_w-1:0]       word_rdata
);

	logic [loader_pkg::bram_word_aw-1:0] core_idx;
	logic                                sel_q;

	// Core reaches only the bottom of each bank
	assign core_idx = {{(loader_pkg::bram_word_aw - loader_pkg::bram_addr_w + 1){1'b0}},
			bram_addr[loader_pkg::bram_addr_w-1:1]};

	// Bank 0 holds even bytes, bank 1 odd bytes
	for (genvar b = 0; b < 2; b++) begin : g_bank
		logic [7:0] mem [2**loader_pkg::bram_word_aw];
		logic [7:0] core_q;
		logic [7:0] word_q;

		always_ff @(posedge clk_sys) begin
			if (bram_we && (bram_addr[0] == 1'(b)))
				mem[core_idx] <= bram_wdata;
			if (word_we)
				mem[word_addr] <= word_wdata[8*b +: 8];
			core_q <= mem[core_idx];
			word_q <= mem[word_addr];
		end
	end

	always_ff @(posedge clk_sys) begin
		sel_q <= bram_addr[0]; // Lines up with the registered bank data
	end

	assign bram_rdata = sel_q ? g_bank[1].core_q : g_bank[0].core_q;
	assign word_rdata = {g_bank[1].word_q, g_bank[0].word_q};

endmodule

//--- source/backup_sync.sv
// Backup sync controller for sector load/save, autosave tracking and RAM format
module backup_sync (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cart_download,
	input  logic                                 osd_open,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic [63:0]                          img_size,
	input  loader_pkg::loader_opts_t             opts,
	input  logic                                 core_write,
	output loader_pkg::sector_req_t              sd_req,
	input  logic                                 sd_ack,
	input  loader_pkg::sector_buf_t              sector_buf,
	output logic [loader_pkg::bram_word_aw-1:0]  word_addr,
	output logic [loader_pkg::word_w-1:0]        word_wdata,
	output logic                                 word_we,
	output logic                                 busy,
	output logic                                 pending,
	output logic                                 core_hold
);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_save
	} state_t;

	state_t     state;
	logic       old_download;
	logic       old_load;
	logic       old_save;
	logic       old_ack;
	logic       old_format;
	logic       bk_ena;
	logic       save_req;
	logic       start_load;
	logic       start_save;
	logic       ack_rise;
	logic       ack_fall;
	logic       last_sector;
	logic [3:0] fmt_step; // Bit 3 set means idle
	logic       fmt_we;

	// Autosave fires when the menu opens with unsaved core writes
	assign save_req    = opts.bk_save | (pending & osd_open & opts.autosave);
	assign start_load  = (opts.bk_load & ~old_load) |
			(old_download & ~cart_download & (|img_size));
	assign start_save  = save_req & ~old_save;
	assign ack_rise    = sd_ack & ~old_ack;
	assign ack_fall    = ~sd_ack & old_ack;
	assign last_sector = (sd_req.lba == 32'(loader_pkg::sector_count - 1));

	assign busy      = (state != st_idle);
	assign core_hold = (state == st_load);

	// ==============================
	// Enable and pending
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
			pending      <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1; // Save image mounts while the cart downloads
			if (bk_ena && !osd_open && core_write)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;
		end
	end

	// ==============================
	// Sector transfer FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= st_idle;
			sd_req   <= '0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= opts.bk_load;
			old_save <= save_req;
			old_ack  <= sd_ack;
			if (ack_rise) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end
			case (state)
				st_idle: begin
					if (bk_ena && (start_load || start_save)) begin
						state      <= start_load ? st_load : st_save; // Load wins
						sd_req.lba <= '0;
						sd_req.rd  <= start_load;
						sd_req.wr  <= ~start_load;
					end
				end
				default: begin
					if (ack_fall) begin
						if (last_sector) begin
							state <= st_idle;
						end else begin
							sd_req.lba <= sd_req.lba + 32'd1;
							sd_req.rd  <= (state == st_load);
							sd_req.wr  <= (state == st_save);
						end
					end
				end
			endcase
		end
	end

	// ==============================
	// Format sequencer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_format <= 1'b0;
			fmt_step   <= 4'h8;
		end else begin
			old_format <= opts.format;
			if (opts.format && !old_format)
				fmt_step <= 4'h0;
			else if (!fmt_step[3])
				fmt_step <= fmt_step + 4'd1;
		end
	end

	assign fmt_we = ~fmt_step[3] & fmt_step[0]; // Odd steps write

	// Word port goes to the sector buffer during a transfer
	always_comb begin
		if (busy) begin
			word_addr  = {sd_req.lba[loader_pkg::sector_sel_w-1:0], sector_buf.addr};
			word_wdata = sector_buf.data;
			word_we    = sector_buf.wr & sd_ack;
		end else begin
			word_addr  = (loader_pkg::bram_word_aw)'(fmt_step[2:1]);
			word_wdata = loader_pkg::bram_default[fmt_step[2:1]];
			word_we    = fmt_we;
		end
	end

endmodule

//--- source/host_loader_top.sv
// Host loader top level splitting downloads into cartridge and cheat traffic and wiring the blocks
module host_loader_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 download,
	input  logic [7:0]                           download_index,
	input  loader_pkg::host_wr_t                 host_wr,
	input  loader_pkg::loader_opts_t             opts,
	input  logic                                 osd_open,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic [63:0]                          img_size,
	output logic                                 ioctl_wait,
	output loader_pkg::rom_wr_t                  rom_wr,
	input  logic                                 rom_ack,
	output loader_pkg::rom_info_t                rom_info,
	output loader_pkg::cheat_code_t              cheat_code,
	output logic                                 code_valid,
	output logic                                 cheat_clear,
	input  logic [loader_pkg::bram_addr_w-1:0]   bram_addr,
	input  logic [7:0]                           bram_wdata,
	input  logic                                 bram_we,
	output logic [7:0]                           bram_rdata,
	output loader_pkg::sector_req_t              sd_req,
	input  logic                                 sd_ack,
	input  loader_pkg::sector_buf_t              sector_buf,
	output logic [loader_pkg::word_w-1:0]        sd_buff_din,
	output logic                                 core_hold,
	output logic                                 save_led
);

	logic                                cart_download;
	logic                                code_download;
	logic [loader_pkg::bram_word_aw-1:0] word_addr;
	logic [loader_pkg::word_w-1:0]       word_wdata;
	logic                                word_we;
	logic                                busy;
	logic                                pending;

	// Index of all ones means a cheat file, anything else is a cartridge
	assign cart_download = download & (download_index != loader_pkg::code_index);
	assign code_download = download & (download_index == loader_pkg::code_index);

	assign save_led = cart_download | busy | (opts.autosave & pending);

	rom_loader u_rom_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cart_download  (cart_download),
		.download_index (download_index),
		.host_wr        (host_wr),
		.rom_swap       (opts.rom_swap),
		.rom_ack        (rom_ack),
		.ioctl_wait     (ioctl_wait),
		.rom_wr         (rom_wr),
		.rom_info       (rom_info)
	);

	cheat_assembler u_cheat_assembler (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.download      (download),
		.host_wr       (host_wr),
		.cheat_code    (cheat_code),
		.code_valid    (code_valid),
		.cheat_clear   (cheat_clear)
	);

	backup_ram u_backup_ram (
		.clk_sys    (clk_sys),
		.bram_addr  (bram_addr),
		.bram_wdata (bram_wdata),
		.bram_we    (bram_we),
		.bram_rdata (bram_rdata),
		.word_addr  (word_addr),
		.word_wdata (word_wdata),
		.word_we    (word_we),
		.word_rdata (sd_buff_din) // Sector data back to the host on a save
	);

	backup_sync u_backup_sync (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.osd_open      (osd_open),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.opts          (opts),
		.core_write    (bram_we),
		.sd_req        (sd_req),
		.sd_ack        (sd_ack),
		.sector_buf    (sector_buf),
		.word_addr     (word_addr),
		.word_wdata    (word_wdata),
		.word_we       (word_we),
		.busy          (busy),
		.pending       (pending),
		.core_hold     (core_hold)
	);

endmodule

//--- test/rom_memory_model.sv
// ROM memory model that stores toggle-requested words and acknowledges after a random delay
module rom_memory_model (
	input  logic                clk_sys,
	input  logic                reset,
	input  loader_pkg::rom_wr_t rom_wr,
	output logic                rom_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] mem [16384]; // Byte addresses below 32 KB
	logic        busy;
	logic [2:0]  delay;

	// New request whenever req and ack differ
	always @(posedge clk_sys) begin
		if (reset) begin
			rom_ack <= 1'b0;
			busy    <= 1'b0;
			delay   <= '0;
		end else if (busy) begin
			if (delay == 3'd0) begin
				mem[rom_wr.addr[14:1]] <= rom_wr.data;
				rom_ack                <= rom_wr.req; // Word stored
				busy                   <= 1'b0;
			end else begin
				delay <= delay - 3'd1;
			end
		end else if (rom_wr.req != rom_ack) begin
			busy  <= 1'b1;
			delay <= 3'($urandom_range(5, 0));
		end
	end

endmodule

//--- test/tb_host_loader.sv
// Host loader testbench with directed ROM, cheat, backup load/save and autosave tests
module tb_host_loader;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeout_cycles = 2000;

	logic                      clk_sys;
	logic                      reset;
	logic                      download;
	logic [7:0]                download_index;
	loader_pkg::host_wr_t      host_wr;
	loader_pkg::loader_opts_t  opts;
	logic                      osd_open;
	logic                      img_mounted;
	logic                      img_readonly;
	logic [63:0]               img_size;
	logic                      ioctl_wait;
	loader_pkg::rom_wr_t       rom_wr;
	logic                      rom_ack;
	loader_pkg::rom_info_t     rom_info;
	loader_pkg::cheat_code_t   cheat_code;
	logic                      code_valid;
	logic                      cheat_clear;
	logic [10:0]               bram_addr;
	logic [7:0]                bram_wdata;
	logic                      bram_we;
	logic [7:0]                bram_rdata;
	loader_pkg::sector_req_t   sd_req;
	logic                      sd_ack;
	loader_pkg::sector_buf_t   sector_buf;
	logic [15:0]               sd_buff_din;
	logic                      core_hold;
	logic                      save_led;

	logic [15:0] sent [64];    // Host words of the last ROM load
	logic [15:0] image [4096]; // Expected backup RAM by word
	int          num_errors;
	int          num_tests;

	host_loader_top DUT (.*);

	rom_memory_model rom_mem (
		.clk_sys (clk_sys),
		.reset   (reset),
		.rom_wr  (rom_wr),
		.rom_ack (rom_ack)
	);

	always #5 clk_sys = ~clk_sys;

	// ==============================
	// Helpers
	// ==============================
	task report_error(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		num_errors++;
	endtask

	task report_timeout(input string what);
		$display("Timeout: %s did not happen in time", what);
		$display("TEST FAILED");
		$finish;
	endtask

	function automatic logic [15:0] reverse_bits(input logic [15:0] w);
		logic [15:0] r;
		for (int i = 0; i < 16; i++)
			r[i] = w[15 - i];
		return {r[7:0], r[15:8]}; // Full reversal also swaps the bytes
	endfunction

	task start_download(input logic [7:0] idx);
		download       = 1'b1;
		download_index = idx;
		@(negedge clk_sys); // Rising edge seen by now
	endtask

	task end_download;
		download = 1'b0;
		@(negedge clk_sys);
	endtask

	// One host word through the wait handshake
	task rom_write(input logic [15:0] data, input logic [23:0] exp_addr);
		int   n;
		logic old_req;
		old_req      = rom_wr.req;
		host_wr.wr   = 1'b1;
		host_wr.addr = {1'b0, exp_addr};
		host_wr.data = data;
		@(negedge clk_sys);
		host_wr.wr = 1'b0;
		if (ioctl_wait !== 1'b1 || rom_wr.req === old_req)
			report_error("ioctl_wait not raised or req not toggled after a host write");
		n = 0;
		while (ioctl_wait && n < timeout_cycles) begin
			@(negedge clk_sys);
			n++;
		end
		if (ioctl_wait)
			report_timeout("ROM write acknowledge");
		if (rom_ack !== rom_wr.req)
			report_error("ioctl_wait dropped before the memory acknowledge");
		if (rom_wr.addr !== exp_addr + 24'd2)
			report_error($sformatf("ROM address %h after acknowledge, expected %h",
					rom_wr.addr, exp_addr + 24'd2));
	endtask

	task core_write_byte(input logic [10:0] a, input logic [7:0] d);
		bram_addr  = a;
		bram_wdata = d;
		bram_we    = 1'b1;
		if (a[0])
			image[a >> 1][15:8] = d;
		else
			image[a >> 1][7:0] = d;
		@(negedge clk_sys);
		bram_we = 1'b0;
	endtask

	task wait_idle;
		int n;
		n = 0;
		while (DUT.busy && n < timeout_cycles) begin
			@(negedge clk_sys);
			n++;
		end
		if (DUT.busy)
			report_timeout("end of the backup transfer");
	endtask

	// Answers 16 sector requests, writing image words on a load, comparing them on a save
	task serve_sectors(input logic is_load);
		int n;
		int base;
		for (int s = 0; s < 16; s++) begin
			n = 0;
			while (!(is_load ? sd_req.rd : sd_req.wr) && n < timeout_cycles) begin
				@(negedge clk_sys);
				n++;
			end
			if (!(is_load ? sd_req.rd : sd_req.wr))
				report_timeout("sector request");
			if (sd_req.lba !== 32'(s))
				report_error($sformatf("Sector lba %0d, expected %0d", sd_req.lba, s));
			base          = s * 256;
			sd_ack        = 1'b1;
			sector_buf.wr = is_load;
			sector_buf.addr = 8'd0;
			for (int k = 0; k < 256; k++) begin
				if (is_load) begin
					image[base + k]  = 16'($urandom);
					sector_buf.addr  = 8'(k);
					sector_buf.data  = image[base + k];
					@(negedge clk_sys);
				end else begin
					@(negedge clk_sys);
					if (sd_buff_din !== image[base + k])
						report_error($sformatf("Save word %0d.%0d is %h, expected %h",
								s, k, sd_buff_din, image[base + k]));
					sector_buf.addr = 8'(k + 1);
				end
				if (core_hold !== is_load)
					report_error("core_hold does not match the transfer kind");
				if (save_led !== 1'b1)
					report_error("save_led low during a backup transfer");
			end
			if (sd_req.rd || sd_req.wr)
				report_error("Sector request not cleared by the acknowledge");
			sector_buf.wr = 1'b0;
			sd_ack        = 1'b0;
			@(negedge clk_sys);
		end
		wait_idle();
		if (core_hold !== 1'b0)
			report_error("core_hold still high after the transfer");
	endtask

	task check_info(input logic [23:0] a);
		// Upper page matched, lower did not, so populous follows the header bit
		if (rom_info.header !== a[9] || rom_info.populous !== a[9] ||
				rom_info.size !== a[23:16])
			report_error($sformatf("rom_info %h at address %h", rom_info, a));
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task load_rom_words(input logic swap);
		logic [15:0] expected;
		num_tests++;
		opts.rom_swap = swap;
		start_download(8'd1);
		if (save_led !== 1'b1)
			report_error("save_led low during a cartridge download");
		for (int i = 0; i < 64; i++) begin
			sent[i] = 16'($urandom);
			rom_write(sent[i], 24'(2 * i));
		end
		end_download();
		if (save_led !== 1'b0)
			report_error("save_led high with no download, transfer or pending save");
		for (int i = 0; i < 64; i++) begin
			expected = swap ? reverse_bits(sent[i]) : sent[i];
			if (rom_mem.mem[i] !== expected)
				report_error($sformatf("ROM word %0d is %h, expected %h",
						i, rom_mem.mem[i], expected));
		end
		opts.rom_swap = 1'b0;
	endtask

	task check_image_flags;
		logic [23:0] a;
		logic [15:0] w;
		num_tests++;
		start_download(8'd2);
		if (rom_info.sgx !== 1'b1 || rom_wr.addr !== 24'd0)
			report_error("sgx or address wrong at start of an index 2 download");
		// Runs past 64 KB so that size leaves zero
		for (int i = 0; i < 'h8100; i++) begin
			a = 24'(2 * i);
			w = 16'($urandom);
			if (a[23:4] == 20'h212 && a[3:0] >= 4'd6 && a[3:0] <= 4'd12)
				w = loader_pkg::pop_sig[(a[3:0] - 4'd6) >> 1];
			else if (a[23:4] == 20'h1F2 && a[3:0] >= 4'd6 && a[3:0] <= 4'd12)
				w = ~loader_pkg::pop_sig[(a[3:0] - 4'd6) >> 1];
			rom_write(w, a);
			if (a == 24'h212E)
				check_info(a + 24'd2); // Header bit clear
		end
		check_info(24'h10200);
		if (rom_info.sgx !== 1'b1)
			report_error("sgx lost during an index 2 load");
		end_download();
		start_download(8'd1);
		for (int i = 0; i < 4; i++)
			rom_write(16'($urandom), 24'(2 * i));
		if (rom_info.sgx !== 1'b0 || rom_info.populous !== 1'b1 ||
				rom_info.header !== 1'b0 || rom_info.size !== 8'd0)
			report_error($sformatf("rom_info %h after an index 1 load", rom_info));
		end_download();
	endtask

	task assemble_cheat;
		logic [15:0]             w [8];
		loader_pkg::cheat_code_t expected;
		int                      valid_pulses;
		int                      clear_pulses;
		num_tests++;
		valid_pulses = 0;
		clear_pulses = 0;
		for (int i = 0; i < 8; i++)
			w[i] = 16'($urandom);
		start_download(loader_pkg::code_index);
		for (int i = 0; i < 8; i++) begin
			host_wr.wr   = 1'b1;
			host_wr.addr = 25'(2 * i);
			host_wr.data = w[i];
			@(negedge clk_sys);
			host_wr.wr   = 1'b0;
			valid_pulses += code_valid;
			clear_pulses += cheat_clear;
			if (i == 7 && code_valid !== 1'b1)
				report_error("code_valid missing after the write at offset 14");
			@(negedge clk_sys);
			valid_pulses += code_valid;
			clear_pulses += cheat_clear;
		end
		repeat (3) begin
			@(negedge clk_sys);
			valid_pulses += code_valid;
			clear_pulses += cheat_clear;
		end
		expected.flags   = {w[1], w[0]};
		expected.addr    = {w[3], w[2]};
		expected.compare = {w[5], w[4]};
		expected.replace = {w[7], w[6]};
		if (cheat_code !== expected)
			report_error($sformatf("cheat_code %h, expected %h", cheat_code, expected));
		if (valid_pulses != 1 || clear_pulses != 1)
			report_error($sformatf("%0d code_valid and %0d cheat_clear pulses, expected 1",
					valid_pulses, clear_pulses));
		end_download();
	endtask

	task load_after_download;
		logic [7:0] expected;
		num_tests++;
		start_download(8'd1);
		img_mounted  = 1'b1; // Writable save image
		img_readonly = 1'b0;
		img_size     = 64'd8192;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		end_download();
		serve_sectors(1'b1);
		bram_addr = 11'd0;
		for (int b = 0; b < 2048; b++) begin
			@(negedge clk_sys);
			expected = b[0] ? image[b >> 1][15:8] : image[b >> 1][7:0];
			if (bram_rdata !== expected)
				report_error($sformatf("Core byte %0d is %h, expected %h",
						b, bram_rdata, expected));
			bram_addr = 11'(b + 1);
		end
	endtask

	task format_then_save;
		num_tests++;
		opts.format = 1'b1;
		for (int i = 0; i < 4; i++)
			image[i] = loader_pkg::bram_default[i];
		repeat (10) @(negedge clk_sys); // Format runs for 8 cycles
		opts.format = 1'b0;
		for (int i = 0; i < 16; i++)
			core_write_byte(11'h100 + 11'(i), 8'($urandom));
		if (save_led !== 1'b0)
			report_error("save_led high for a pending save with autosave off");
		opts.bk_save = 1'b1;
		serve_sectors(1'b0);
		opts.bk_save = 1'b0;
		@(negedge clk_sys);
	endtask

	task autosave_on_menu;
		int n;
		num_tests++;
		opts.autosave = 1'b1;
		core_write_byte(11'h200, 8'($urandom));
		if (DUT.pending !== 1'b1)
			report_error("pending not set by a core write");
		if (save_led !== 1'b1)
			report_error("save_led low for a pending save with autosave on");
		osd_open = 1'b1;
		n = 0;
		while (!sd_req.wr && n < timeout_cycles) begin
			@(negedge clk_sys);
			n++;
		end
		if (!sd_req.wr)
			report_timeout("autosave sector write");
		@(negedge clk_sys);
		if (DUT.pending !== 1'b0)
			report_error("pending not cleared once the save started");
		serve_sectors(1'b0);
		osd_open      = 1'b0;
		opts.autosave = 1'b0;
		@(negedge clk_sys);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		void'($urandom(32'h4d));
		num_errors     = 0;
		num_tests      = 0;
		clk_sys        = 1'b0;
		reset          = 1'b1;
		download       = 1'b0;
		download_index = 8'd0;
		host_wr        = '0;
		opts           = '0;
		osd_open       = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b1;
		img_size       = 64'd0;
		bram_addr      = '0;
		bram_wdata     = 8'd0;
		bram_we        = 1'b0;
		sd_ack         = 1'b0;
		sector_buf     = '0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		if (ioctl_wait !== 1'b0 || rom_wr.req !== 1'b0 || sd_req.rd !== 1'b0 ||
				sd_req.wr !== 1'b0 || core_hold !== 1'b0 || DUT.pending !== 1'b0 ||
				DUT.busy !== 1'b0 || save_led !== 1'b0 ||
				code_valid !== 1'b0 || cheat_clear !== 1'b0)
			report_error("Outputs not idle after reset");
		load_rom_words(1'b0);
		load_rom_words(1'b1);
		check_image_flags();
		assemble_cheat();
		load_after_download();
		format_then_save();
		autosave_on_menu();
		$display("Tests run: %0d, errors: %0d", num_tests, num_errors);
		if (num_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- list.f
source/loader_pkg.sv
source/rom_loader.sv
source/cheat_assembler.sv
source/backup_ram.sv
source/backup_sync.sv
source/host_loader_top.sv
test/rom_memory_model.sv
test/tb_host_loader.sv
